// File: sim.f
design/scope_cfg_pkg.sv
design/scope_cfg_decode.sv
design/scope_cfg_cmd.sv
design/scope_cfg_regs.sv
design/scope_cfg_share.sv
design/scope_cfg_readback.sv
design/scope_cfg_top.sv
tb/tb_scope_cfg.sv

// File: Makefile
# Verilator build and run for the scope register block testbench

VERILATOR ?= verilator
TOP       ?= tb_scope_cfg
FILELIST  ?= sim.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing -j 0

.PHONY: all compile run clean

all: run

compile:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD_DIR)

run: compile
	@./$(BUILD_DIR)/V$(TOP) > $(LOG) 2>&1; rc=$$?; cat $(LOG); \
	  if [ $$rc -ne 0 ] || grep -q "SIMULATION FAILED" $(LOG); then exit 1; fi

clean:
	rm -rf $(BUILD_DIR) $(LOG)

// File: tb/tb_scope_cfg.sv
// ====================
// Testbench for the scope register block:
// clock, reset, bus tasks, typed compares,
// directed tests and timeout
// ====================
`timescale 1ns/1ns

module tb_scope_cfg;

  import scope_cfg_pkg::*;

  localparam int    MAX_CYCLES = 2000;
  localparam word_t MASK_DW    = word_t'((64'd1 << DW) - 64'd1);
  localparam word_t MASK_DLY   = word_t'((64'd1 << DLY_W) - 64'd1);
  localparam word_t MASK_DEC   = word_t'((64'd1 << DEC_W) - 64'd1);

  logic     adc_clk;
  logic     adc_rstn;
  word_t    sys_addr;
  word_t    sys_wdata;
  logic     sys_wen;
  logic     sys_ren;
  word_t    sys_rdata;
  logic     sys_ack;
  word_t    adc_state;
  word_t    trg_state;
  wp_t      wp_cur       [N_CH];
  wp_t      wp_trig      [N_CH];
  logic     arm_do       [N_CH];
  logic     rst_do       [N_CH];
  logic     trig_sw      [N_CH];
  logic     we_keep      [N_CH];
  logic     trig_dis_clr [N_CH];
  logic     indep_mode   [N_CH];
  logic     new_trg_src  [N_CH];
  trg_src_t trg_src      [N_CH];
  sample_t  set_tresh    [N_CH];
  sample_t  set_hyst     [N_CH];
  dly_t     set_dly      [N_CH];
  dec_t     set_dec      [N_CH];
  logic     set_dec1     [N_CH];

  int   value_errs;
  int   proto_errs;
  int   cycle_cnt;
  dly_t exp_dly [N_CH];  // Raw per-channel settings
  dec_t exp_dec [N_CH];

  scope_cfg_top uut (
    .adc_clk_i      (adc_clk),
    .adc_rstn_i     (adc_rstn),
    .sys_addr_i     (sys_addr),
    .sys_wdata_i    (sys_wdata),
    .sys_wen_i      (sys_wen),
    .sys_ren_i      (sys_ren),
    .sys_rdata_o    (sys_rdata),
    .sys_ack_o      (sys_ack),
    .adc_state_i    (adc_state),
    .trg_state_i    (trg_state),
    .adc_wp_cur_i   (wp_cur),
    .adc_wp_trig_i  (wp_trig),
    .adc_arm_do_o   (arm_do),
    .adc_rst_do_o   (rst_do),
    .adc_trig_sw_o  (trig_sw),
    .adc_we_keep_o  (we_keep),
    .trig_dis_clr_o (trig_dis_clr),
    .indep_mode_o   (indep_mode),
    .new_trg_src_o  (new_trg_src),
    .trg_src_o      (trg_src),
    .set_tresh_o    (set_tresh),
    .set_hyst_o     (set_hyst),
    .set_dly_o      (set_dly),
    .set_dec_o      (set_dec),
    .set_dec1_o     (set_dec1)
  );

  initial begin
    adc_clk = 1'b0;
    forever #50 adc_clk = ~adc_clk;
  end

  initial begin : watchdog
    cycle_cnt = 0;
    while (cycle_cnt < MAX_CYCLES) begin
      @(posedge adc_clk);
      cycle_cnt++;
    end
    $display("Timeout: run did not finish within %0d cycles", MAX_CYCLES);
    $display("SIMULATION FAILED");
    $finish;
  end

  task automatic check_word(input string name, input word_t got, input word_t exp);
    if (got !== exp) begin
      $display("ERR %s got 0x%08h expected 0x%08h", name, got, exp);
      value_errs++;
    end
  endtask

  task automatic check_sample(input string name, input sample_t got, input sample_t exp);
    if (got !== exp) begin
      $display("ERR %s got 0x%04h expected 0x%04h", name, got, exp);
      value_errs++;
    end
  endtask

  task automatic check_dly(input string name, input dly_t got, input dly_t exp);
    if (got !== exp) begin
      $display("ERR %s got 0x%08h expected 0x%08h", name, got, exp);
      value_errs++;
    end
  endtask

  task automatic check_dec(input string name, input dec_t got, input dec_t exp);
    if (got !== exp) begin
      $display("ERR %s got 0x%05h expected 0x%05h", name, got, exp);
      value_errs++;
    end
  endtask

  task automatic check_trg(input string name, input trg_src_t got, input trg_src_t exp);
    if (got !== exp) begin
      $display("ERR %s got 0x%01h expected 0x%01h", name, got, exp);
      value_errs++;
    end
  endtask

  task automatic check_bit(input string name, input logic got, input logic exp);
    if (got !== exp) begin
      $display("ERR %s got 0x%01h expected 0x%01h", name, got, exp);
      value_errs++;
    end
  endtask

  task automatic next_cycle();
    @(posedge adc_clk);
    #10;
  endtask

  // Strobe for one cycle, ack expected in the next
  task automatic bus_write(input logic [ADDR_W-1:0] addr, input word_t data);
    sys_addr  = word_t'(addr);
    sys_wdata = data;
    sys_wen   = 1'b1;
    next_cycle();
    sys_wen = 1'b0;
    if (sys_ack !== 1'b1) begin
      $display("No ack in the cycle after a write to address 0x%05h", addr);
      proto_errs++;
    end
  endtask

  task automatic bus_read(input logic [ADDR_W-1:0] addr, output word_t data);
    sys_addr = word_t'(addr);
    sys_ren  = 1'b1;
    next_cycle();
    sys_ren = 1'b0;
    data    = sys_rdata;
    if (sys_ack !== 1'b1) begin
      $display("No ack in the cycle after a read from address 0x%05h", addr);
      proto_errs++;
    end
  endtask

  task automatic write_readback(input string name, input logic [ADDR_W-1:0] addr,
                                input word_t data, input word_t mask);
    word_t rd;
    bus_write(addr, data);
    bus_read(addr, rd);
    check_word(name, rd, data & mask);
  endtask

  task automatic check_pulses_low(input int ch);
    check_bit($sformatf("adc_arm_do_o[%0d]", ch), arm_do[ch], 1'b0);
    check_bit($sformatf("adc_rst_do_o[%0d]", ch), rst_do[ch], 1'b0);
    check_bit($sformatf("adc_trig_sw_o[%0d]", ch), trig_sw[ch], 1'b0);
    check_bit($sformatf("trig_dis_clr_o[%0d]", ch), trig_dis_clr[ch], 1'b0);
    check_bit($sformatf("new_trg_src_o[%0d]", ch), new_trg_src[ch], 1'b0);
  endtask

  task automatic test_reset_defaults();
    word_t rd;
    check_bit("sys_ack_o", sys_ack, 1'b0);
    bus_read(ADR_TRESH0, rd);
    check_word("TRESH0", rd, word_t'(5000));
    bus_read(ADR_TRESH1, rd);
    check_word("TRESH1", rd, word_t'((1 << DW) - 5000));  // -5000 in DW bits
    bus_read(ADR_HYST0, rd);
    check_word("HYST0", rd, word_t'(20));
    bus_read(ADR_HYST1, rd);
    check_word("HYST1", rd, word_t'(20));
    bus_read(ADR_DEC0, rd);
    check_word("DEC0", rd, word_t'(1));
    bus_read(ADR_DEC1, rd);
    check_word("DEC1", rd, word_t'(1));
    bus_read(ADR_DLY0, rd);
    check_word("DLY0", rd, '0);
    bus_read(ADR_DLY1, rd);
    check_word("DLY1", rd, '0);
    for (int ch = 0; ch < N_CH; ch++) begin
      exp_dly[ch] = '0;
      exp_dec[ch] = dec_t'(1);
      check_bit($sformatf("set_dec1_o[%0d]", ch), set_dec1[ch], 1'b1);
      check_bit($sformatf("adc_we_keep_o[%0d]", ch), we_keep[ch], 1'b0);
      check_bit($sformatf("indep_mode_o[%0d]", ch), indep_mode[ch], 1'b0);
      check_trg($sformatf("trg_src_o[%0d]", ch), trg_src[ch], '0);
      check_pulses_low(ch);
    end
  endtask

  task automatic test_settings();
    word_t data;
    data = $urandom;
    write_readback("TRESH0", ADR_TRESH0, data, MASK_DW);
    check_sample("set_tresh_o[0]", set_tresh[0], sample_t'(data));
    data = $urandom;
    write_readback("TRESH1", ADR_TRESH1, data, MASK_DW);
    check_sample("set_tresh_o[1]", set_tresh[1], sample_t'(data));
    data = $urandom;
    write_readback("HYST0", ADR_HYST0, data, MASK_DW);
    check_sample("set_hyst_o[0]", set_hyst[0], sample_t'(data));
    data = $urandom;
    write_readback("HYST1", ADR_HYST1, data, MASK_DW);
    data = $urandom;
    exp_dly[0] = dly_t'(data);
    write_readback("DLY0", ADR_DLY0, data, MASK_DLY);
    check_dly("set_dly_o[0]", set_dly[0], exp_dly[0]);
    data = $urandom;
    exp_dly[1] = dly_t'(data);
    write_readback("DLY1", ADR_DLY1, data, MASK_DLY);
    data = $urandom;
    exp_dec[0] = dec_t'(data);
    write_readback("DEC0", ADR_DEC0, data, MASK_DEC);
    check_dec("set_dec_o[0]", set_dec[0], exp_dec[0]);
    check_bit("set_dec1_o[0]", set_dec1[0], exp_dec[0] == dec_t'(1));
    data = $urandom;
    exp_dec[1] = dec_t'(data);
    write_readback("DEC1", ADR_DEC1, data, MASK_DEC);
  endtask

  task automatic test_ctrl_pulses();
    bus_write(ADR_CTRL, word_t'(1) << CTL_ARM);
    check_bit("adc_arm_do_o[0]", arm_do[0], 1'b1);
    check_bit("adc_rst_do_o[0]", rst_do[0], 1'b0);
    next_cycle();
    check_bit("adc_arm_do_o[0]", arm_do[0], 1'b0);
    check_bit("sys_ack_o", sys_ack, 1'b0);  // Ack lasts one cycle
    bus_write(ADR_CTRL, word_t'(1) << CTL_RST);
    check_bit("adc_rst_do_o[0]", rst_do[0], 1'b1);
    check_bit("adc_arm_do_o[0]", arm_do[0], 1'b0);
    next_cycle();
    check_bit("adc_rst_do_o[0]", rst_do[0], 1'b0);
    bus_write(ADR_CTRL, word_t'(1) << CTL_KEEP);
    check_bit("adc_we_keep_o[0]", we_keep[0], 1'b1);
    repeat (3) next_cycle();
    check_bit("adc_we_keep_o[0]", we_keep[0], 1'b1);  // Still latched
    bus_write(ADR_CTRL, '0);
    check_bit("adc_we_keep_o[0]", we_keep[0], 1'b0);
  endtask

  task automatic test_common_mode();
    word_t ctl;
    bus_write(ADR_DEC1, word_t'(1));
    exp_dec[1] = dec_t'(1);
    check_dly("set_dly_o[1]", set_dly[1], exp_dly[0]);  // Follows channel 0
    check_dec("set_dec_o[1]", set_dec[1], exp_dec[0]);
    check_bit("set_dec1_o[1]", set_dec1[1], exp_dec[0] == dec_t'(1));
    ctl = (word_t'(1) << CTL_ARM) | (word_t'(1) << (8 + CTL_RST));
    bus_write(ADR_CTRL, ctl);
    check_bit("adc_arm_do_o[1]", arm_do[1], 1'b1);
    check_bit("adc_rst_do_o[1]", rst_do[1], 1'b0);
    next_cycle();
    ctl = ctl | (word_t'(1) << (8 + CTL_INDEP));
    bus_write(ADR_CTRL, ctl);
    check_bit("indep_mode_o[1]", indep_mode[1], 1'b1);
    check_bit("indep_mode_o[0]", indep_mode[0], 1'b0);
    check_bit("adc_arm_do_o[0]", arm_do[0], 1'b1);
    check_bit("adc_rst_do_o[0]", rst_do[0], 1'b0);
    check_bit("adc_arm_do_o[1]", arm_do[1], 1'b0);
    check_bit("adc_rst_do_o[1]", rst_do[1], 1'b1);
    check_dly("set_dly_o[1]", set_dly[1], exp_dly[1]);
    check_dec("set_dec_o[1]", set_dec[1], exp_dec[1]);
    check_bit("set_dec1_o[1]", set_dec1[1], 1'b1);
    next_cycle();
    check_pulses_low(0);
    check_pulses_low(1);
    bus_write(ADR_CTRL, '0);  // Back to common mode
    check_bit("indep_mode_o[1]", indep_mode[1], 1'b0);
    check_dly("set_dly_o[1]", set_dly[1], exp_dly[0]);
  endtask

  task automatic test_trigger_source();
    word_t rd;
    bus_write(ADR_TRG, word_t'(1));
    for (int ch = 0; ch < N_CH; ch++) begin
      check_bit($sformatf("new_trg_src_o[%0d]", ch), new_trg_src[ch], 1'b1);
      check_bit($sformatf("adc_trig_sw_o[%0d]", ch), trig_sw[ch], 1'b1);
      check_trg($sformatf("trg_src_o[%0d]", ch), trg_src[ch], trg_src_t'(1));
    end
    next_cycle();
    check_pulses_low(0);
    check_trg("trg_src_o[0]", trg_src[0], trg_src_t'(1));
    bus_write(ADR_TRG, word_t'(5));
    check_bit("new_trg_src_o[0]", new_trg_src[0], 1'b1);
    check_bit("adc_trig_sw_o[0]", trig_sw[0], 1'b0);
    check_trg("trg_src_o[0]", trg_src[0], trg_src_t'(5));
    bus_write(ADR_TRG, '0);
    check_bit("new_trg_src_o[0]", new_trg_src[0], 1'b0);
    check_trg("trg_src_o[0]", trg_src[0], trg_src_t'(5));  // Zero keeps source
    bus_write(ADR_TRG_CLR, word_t'(1));
    check_bit("trig_dis_clr_o[0]", trig_dis_clr[0], 1'b1);
    check_bit("trig_dis_clr_o[1]", trig_dis_clr[1], 1'b1);
    next_cycle();
    check_bit("trig_dis_clr_o[0]", trig_dis_clr[0], 1'b0);
    bus_read(ADR_TRG_CLR, rd);
    check_word("TRG_CLR", rd, '0);
  endtask

  task automatic test_status_reads();
    word_t rd;
    adc_state = $urandom;
    trg_state = $urandom;
    for (int ch = 0; ch < N_CH; ch++) begin
      wp_cur[ch]  = wp_t'($urandom);
      wp_trig[ch] = wp_t'($urandom);
    end
    bus_read(ADR_CTRL, rd);
    check_word("adc_state", rd, adc_state);
    bus_read(ADR_TRG, rd);
    check_word("trg_state", rd, trg_state);
    bus_read(ADR_WP_CUR0, rd);
    check_word("WP_CUR0", rd, word_t'(wp_cur[0]));
    bus_read(ADR_WP_CUR1, rd);
    check_word("WP_CUR1", rd, word_t'(wp_cur[1]));
    bus_read(ADR_WP_TRIG0, rd);
    check_word("WP_TRIG0", rd, word_t'(wp_trig[0]));
    bus_read(ADR_WP_TRIG1, rd);
    check_word("WP_TRIG1", rd, word_t'(wp_trig[1]));
    bus_read(20'h00028, rd);
    check_word("unmapped 0x28", rd, '0);
    bus_read(20'h00200, rd);
    check_word("unmapped 0x200", rd, '0);
  endtask

  initial begin : main_seq
    value_errs = 0;
    proto_errs = 0;
    adc_rstn   = 1'b0;
    sys_addr   = '0;
    sys_wdata  = '0;
    sys_wen    = 1'b0;
    sys_ren    = 1'b0;
    adc_state  = '0;
    trg_state  = '0;
    for (int ch = 0; ch < N_CH; ch++) begin
      wp_cur[ch]  = '0;
      wp_trig[ch] = '0;
    end
    void'($urandom(60));
    repeat (16) @(posedge adc_clk);
    #10;
    adc_rstn = 1'b1;
    test_reset_defaults();
    test_settings();
    test_ctrl_pulses();
    test_common_mode();
    test_trigger_source();
    test_status_reads();
    $display("Errors: %0d value mismatches, %0d bus failures", value_errs, proto_errs);
    if (value_errs == 0 && proto_errs == 0) begin
      $display("SIMULATION PASSED");
    end else begin
      $display("SIMULATION FAILED");
    end
    $finish;
  end

endmodule

// File: design/scope_cfg_top.sv
// ====================
// Scope register block top level
// ====================
`timescale 1ns/1ns

module scope_cfg_top (
  input  logic                      adc_clk_i,
  input  logic                      adc_rstn_i,
  input  scope_cfg_pkg::word_t      sys_addr_i,
  input  scope_cfg_pkg::word_t      sys_wdata_i,
  input  logic                      sys_wen_i,
  input  logic                      sys_ren_i,
  output scope_cfg_pkg::word_t      sys_rdata_o,
  output logic                      sys_ack_o,
  input  scope_cfg_pkg::word_t      adc_state_i,
  input  scope_cfg_pkg::word_t      trg_state_i,
  input  scope_cfg_pkg::wp_t        adc_wp_cur_i   [scope_cfg_pkg::N_CH],
  input  scope_cfg_pkg::wp_t        adc_wp_trig_i  [scope_cfg_pkg::N_CH],
  output logic                      adc_arm_do_o   [scope_cfg_pkg::N_CH],
  output logic                      adc_rst_do_o   [scope_cfg_pkg::N_CH],
  output logic                      adc_trig_sw_o  [scope_cfg_pkg::N_CH],
  output logic                      adc_we_keep_o  [scope_cfg_pkg::N_CH],
  output logic                      trig_dis_clr_o [scope_cfg_pkg::N_CH],
  output logic                      indep_mode_o   [scope_cfg_pkg::N_CH],
  output logic                      new_trg_src_o  [scope_cfg_pkg::N_CH],
  output scope_cfg_pkg::trg_src_t   trg_src_o      [scope_cfg_pkg::N_CH],
  output scope_cfg_pkg::sample_t    set_tresh_o    [scope_cfg_pkg::N_CH],
  output scope_cfg_pkg::sample_t    set_hyst_o     [scope_cfg_pkg::N_CH],
  output scope_cfg_pkg::dly_t       set_dly_o      [scope_cfg_pkg::N_CH],
  output scope_cfg_pkg::dec_t       set_dec_o      [scope_cfg_pkg::N_CH],
  output logic                      set_dec1_o     [scope_cfg_pkg::N_CH]
);

  import scope_cfg_pkg::*;

  reg_sel_t sel;
  logic     arm         [N_CH];
  logic     rst         [N_CH];
  logic     trig_sw     [N_CH];
  logic     trig_clr    [N_CH];
  logic     new_trg_src [N_CH];
  logic     we_keep     [N_CH];
  trg_src_t trg_src     [N_CH];
  dly_t     dly         [N_CH];  // Raw, before channel sharing
  dec_t     dec         [N_CH];

  scope_cfg_decode u_decode (
    .sys_addr_i (sys_addr_i[ADDR_W-1:0]),
    .sel_o      (sel)
  );

  scope_cfg_cmd u_cmd (
    .adc_clk_i     (adc_clk_i),
    .adc_rstn_i    (adc_rstn_i),
    .sys_wen_i     (sys_wen_i),
    .sys_wdata_i   (sys_wdata_i),
    .sel_i         (sel),
    .arm_o         (arm),
    .rst_o         (rst),
    .trig_sw_o     (trig_sw),
    .trig_clr_o    (trig_clr),
    .new_trg_src_o (new_trg_src),
    .we_keep_o     (we_keep),
    .indep_mode_o  (indep_mode_o),
    .trg_src_o     (trg_src)
  );

  scope_cfg_regs u_regs (
    .adc_clk_i   (adc_clk_i),
    .adc_rstn_i  (adc_rstn_i),
    .sys_wen_i   (sys_wen_i),
    .sys_wdata_i (sys_wdata_i),
    .sel_i       (sel),
    .tresh_o     (set_tresh_o),
    .hyst_o      (set_hyst_o),
    .dly_o       (dly),
    .dec_o       (dec)
  );

  scope_cfg_share u_share (
    .indep_mode_i  (indep_mode_o),
    .arm_i         (arm),
    .rst_i         (rst),
    .trig_sw_i     (trig_sw),
    .trig_clr_i    (trig_clr),
    .new_trg_src_i (new_trg_src),
    .we_keep_i     (we_keep),
    .trg_src_i     (trg_src),
    .dly_i         (dly),
    .dec_i         (dec),
    .arm_o         (adc_arm_do_o),
    .rst_o         (adc_rst_do_o),
    .trig_sw_o     (adc_trig_sw_o),
    .trig_clr_o    (trig_dis_clr_o),
    .new_trg_src_o (new_trg_src_o),
    .we_keep_o     (adc_we_keep_o),
    .trg_src_o     (trg_src_o),
    .dly_o         (set_dly_o),
    .dec_o         (set_dec_o),
    .dec_one_o     (set_dec1_o)
  );

  scope_cfg_readback u_readback (
    .adc_clk_i   (adc_clk_i),
    .adc_rstn_i  (adc_rstn_i),
    .sys_wen_i   (sys_wen_i),
    .sys_ren_i   (sys_ren_i),
    .sel_i       (sel),
    .tresh_i     (set_tresh_o),
    .hyst_i      (set_hyst_o),
    .dly_i       (dly),
    .dec_i       (dec),
    .adc_state_i (adc_state_i),
    .trg_state_i (trg_state_i),
    .wp_cur_i    (adc_wp_cur_i),
    .wp_trig_i   (adc_wp_trig_i),
    .sys_rdata_o (sys_rdata_o),
    .sys_ack_o   (sys_ack_o)
  );

endmodule

// File: design/scope_cfg_readback.sv
// ====================
// Read data multiplexer and bus acknowledge
// ====================
`timescale 1ns/1ns

module scope_cfg_readback (
  input  logic                      adc_clk_i,
  input  logic                      adc_rstn_i,
  input  logic                      sys_wen_i,
  input  logic                      sys_ren_i,
  input  scope_cfg_pkg::reg_sel_t   sel_i,
  input  scope_cfg_pkg::sample_t    tresh_i   [scope_cfg_pkg::N_CH],
  input  scope_cfg_pkg::sample_t    hyst_i    [scope_cfg_pkg::N_CH],
  input  scope_cfg_pkg::dly_t       dly_i     [scope_cfg_pkg::N_CH],
  input  scope_cfg_pkg::dec_t       dec_i     [scope_cfg_pkg::N_CH],
  input  scope_cfg_pkg::word_t      adc_state_i,
  input  scope_cfg_pkg::word_t      trg_state_i,
  input  scope_cfg_pkg::wp_t        wp_cur_i  [scope_cfg_pkg::N_CH],
  input  scope_cfg_pkg::wp_t        wp_trig_i [scope_cfg_pkg::N_CH],
  output scope_cfg_pkg::word_t      sys_rdata_o,
  output logic                      sys_ack_o
);

  import scope_cfg_pkg::*;

  word_t rd_mux;

  always_comb begin
    case (sel_i)
      SEL_CTRL:     rd_mux = adc_state_i;  // Status shares the command addresses
      SEL_TRG:      rd_mux = trg_state_i;
      SEL_TRESH0:   rd_mux = word_t'(tresh_i[0]);
      SEL_TRESH1:   rd_mux = word_t'(tresh_i[1]);
      SEL_HYST0:    rd_mux = word_t'(hyst_i[0]);
      SEL_HYST1:    rd_mux = word_t'(hyst_i[1]);
      SEL_DLY0:     rd_mux = word_t'(dly_i[0]);
      SEL_DLY1:     rd_mux = word_t'(dly_i[1]);
      SEL_DEC0:     rd_mux = word_t'(dec_i[0]);
      SEL_DEC1:     rd_mux = word_t'(dec_i[1]);
      SEL_WP_CUR0:  rd_mux = word_t'(wp_cur_i[0]);
      SEL_WP_CUR1:  rd_mux = word_t'(wp_cur_i[1]);
      SEL_WP_TRIG0: rd_mux = word_t'(wp_trig_i[0]);
      SEL_WP_TRIG1: rd_mux = word_t'(wp_trig_i[1]);
      default:      rd_mux = '0;  // TRG_CLR and unmapped
    endcase
  end

  always_ff @(posedge adc_clk_i) begin
    if (!adc_rstn_i) begin
      sys_ack_o <= 1'b0;
    end else begin
      sys_ack_o <= sys_wen_i || sys_ren_i;
    end
  end

  always_ff @(posedge adc_clk_i) begin
    if (sys_ren_i) begin
      sys_rdata_o <= rd_mux;  // Sampled in the strobe cycle
    end
  end

endmodule

// File: design/scope_cfg_share.sv
// ====================
// Common/independent channel selection
// and decimation-is-one flag
// ====================
`timescale 1ns/1ns

module scope_cfg_share (
  input  logic                    indep_mode_i  [scope_cfg_pkg::N_CH],
  input  logic                    arm_i         [scope_cfg_pkg::N_CH],
  input  logic                    rst_i         [scope_cfg_pkg::N_CH],
  input  logic                    trig_sw_i     [scope_cfg_pkg::N_CH],
  input  logic                    trig_clr_i    [scope_cfg_pkg::N_CH],
  input  logic                    new_trg_src_i [scope_cfg_pkg::N_CH],
  input  logic                    we_keep_i     [scope_cfg_pkg::N_CH],
  input  scope_cfg_pkg::trg_src_t trg_src_i     [scope_cfg_pkg::N_CH],
  input  scope_cfg_pkg::dly_t     dly_i         [scope_cfg_pkg::N_CH],
  input  scope_cfg_pkg::dec_t     dec_i         [scope_cfg_pkg::N_CH],
  output logic                    arm_o         [scope_cfg_pkg::N_CH],
  output logic                    rst_o         [scope_cfg_pkg::N_CH],
  output logic                    trig_sw_o     [scope_cfg_pkg::N_CH],
  output logic                    trig_clr_o    [scope_cfg_pkg::N_CH],
  output logic                    new_trg_src_o [scope_cfg_pkg::N_CH],
  output logic                    we_keep_o     [scope_cfg_pkg::N_CH],
  output scope_cfg_pkg::trg_src_t trg_src_o     [scope_cfg_pkg::N_CH],
  output scope_cfg_pkg::dly_t     dly_o         [scope_cfg_pkg::N_CH],
  output scope_cfg_pkg::dec_t     dec_o         [scope_cfg_pkg::N_CH],
  output logic                    dec_one_o     [scope_cfg_pkg::N_CH]
);

  import scope_cfg_pkg::*;

  for (genvar ch = 0; ch < N_CH; ch++) begin : g_ch
    logic own;

    assign own = (ch == 0) || indep_mode_i[ch];  // Otherwise follow channel 0

    assign arm_o[ch]         = own ? arm_i[ch]         : arm_i[0];
    assign rst_o[ch]         = own ? rst_i[ch]         : rst_i[0];
    assign trig_sw_o[ch]     = own ? trig_sw_i[ch]     : trig_sw_i[0];
    assign trig_clr_o[ch]    = own ? trig_clr_i[ch]    : trig_clr_i[0];
    assign new_trg_src_o[ch] = own ? new_trg_src_i[ch] : new_trg_src_i[0];
    assign we_keep_o[ch]     = own ? we_keep_i[ch]     : we_keep_i[0];
    assign trg_src_o[ch]     = own ? trg_src_i[ch]     : trg_src_i[0];
    assign dly_o[ch]         = own ? dly_i[ch]         : dly_i[0];
    assign dec_o[ch]         = own ? dec_i[ch]         : dec_i[0];
    assign dec_one_o[ch]     = (dec_o[ch] == dec_t'(1));
  end

endmodule

// File: design/scope_cfg_regs.sv
// ====================
// Per-channel threshold, hysteresis,
// delay and decimation settings
// ====================
`timescale 1ns/1ns

module scope_cfg_regs (
  input  logic                      adc_clk_i,
  input  logic                      adc_rstn_i,
  input  logic                      sys_wen_i,
  input  scope_cfg_pkg::word_t      sys_wdata_i,
  input  scope_cfg_pkg::reg_sel_t   sel_i,
  output scope_cfg_pkg::sample_t    tresh_o [scope_cfg_pkg::N_CH],
  output scope_cfg_pkg::sample_t    hyst_o  [scope_cfg_pkg::N_CH],
  output scope_cfg_pkg::dly_t       dly_o   [scope_cfg_pkg::N_CH],
  output scope_cfg_pkg::dec_t       dec_o   [scope_cfg_pkg::N_CH]
);

  import scope_cfg_pkg::*;

  sample_t wr_sample;
  dly_t    wr_dly;
  dec_t    wr_dec;

  assign wr_sample = sys_wdata_i[DW-1:0];
  assign wr_dly    = sys_wdata_i[DLY_W-1:0];
  assign wr_dec    = sys_wdata_i[DEC_W-1:0];

  always_ff @(posedge adc_clk_i) begin
    if (!adc_rstn_i) begin
      tresh_o[0] <= TRESH_RST0;
      tresh_o[1] <= TRESH_RST1;
      for (int ch = 0; ch < N_CH; ch++) begin
        hyst_o[ch] <= HYST_RST;
        dly_o[ch]  <= DLY_RST;
        dec_o[ch]  <= DEC_RST;
      end
    end else if (sys_wen_i) begin
      case (sel_i)
        SEL_TRESH0: tresh_o[0] <= wr_sample;
        SEL_TRESH1: tresh_o[1] <= wr_sample;
        SEL_HYST0:  hyst_o[0]  <= wr_sample;
        SEL_HYST1:  hyst_o[1]  <= wr_sample;
        SEL_DLY0:   dly_o[0]   <= wr_dly;
        SEL_DLY1:   dly_o[1]   <= wr_dly;
        SEL_DEC0:   dec_o[0]   <= wr_dec;
        SEL_DEC1:   dec_o[1]   <= wr_dec;
        default: ;  // Other registers live elsewhere
      endcase
    end
  end

endmodule

// File: design/scope_cfg_cmd.sv
// ====================
// Per-channel command pulses, mode bits
// and stored trigger source
// ====================
`timescale 1ns/1ns

module scope_cfg_cmd (
  input  logic                      adc_clk_i,
  input  logic                      adc_rstn_i,
  input  logic                      sys_wen_i,
  input  scope_cfg_pkg::word_t      sys_wdata_i,
  input  scope_cfg_pkg::reg_sel_t   sel_i,
  output logic                      arm_o         [scope_cfg_pkg::N_CH],
  output logic                      rst_o         [scope_cfg_pkg::N_CH],
  output logic                      trig_sw_o     [scope_cfg_pkg::N_CH],
  output logic                      trig_clr_o    [scope_cfg_pkg::N_CH],
  output logic                      new_trg_src_o [scope_cfg_pkg::N_CH],
  output logic                      we_keep_o     [scope_cfg_pkg::N_CH],
  output logic                      indep_mode_o  [scope_cfg_pkg::N_CH],
  output scope_cfg_pkg::trg_src_t   trg_src_o     [scope_cfg_pkg::N_CH]
);

  import scope_cfg_pkg::*;

  logic wr_ctrl;
  logic wr_trg;
  logic wr_clr;

  assign wr_ctrl = sys_wen_i && (sel_i == SEL_CTRL);
  assign wr_trg  = sys_wen_i && (sel_i == SEL_TRG);
  assign wr_clr  = sys_wen_i && (sel_i == SEL_TRG_CLR);

  for (genvar ch = 0; ch < N_CH; ch++) begin : g_ch
    logic [7:0] lane;

    assign lane = sys_wdata_i[8*ch +: 8];  // Channel n owns byte n

    always_ff @(posedge adc_clk_i) begin
      if (!adc_rstn_i) begin
        arm_o[ch]         <= 1'b0;
        rst_o[ch]         <= 1'b0;
        trig_sw_o[ch]     <= 1'b0;
        trig_clr_o[ch]    <= 1'b0;
        new_trg_src_o[ch] <= 1'b0;
        we_keep_o[ch]     <= 1'b0;
        indep_mode_o[ch]  <= 1'b0;
        trg_src_o[ch]     <= '0;
      end else begin
        arm_o[ch]         <= wr_ctrl && lane[CTL_ARM];
        rst_o[ch]         <= wr_ctrl && lane[CTL_RST];
        trig_sw_o[ch]     <= wr_trg && (lane[3:0] == 4'h1);  // Software trigger
        trig_clr_o[ch]    <= wr_clr && lane[0];
        new_trg_src_o[ch] <= wr_trg && (lane != 8'h00);
        if (wr_ctrl) begin
          we_keep_o[ch]    <= lane[CTL_KEEP];
          indep_mode_o[ch] <= lane[CTL_INDEP];
        end
        if (wr_trg && (lane != 8'h00)) begin
          trg_src_o[ch] <= lane[TRG_W-1:0];  // Zero byte keeps source
        end
      end
    end
  end

endmodule

// File: design/scope_cfg_decode.sv
// ====================
// Bus address decoder to register selector
// ====================
`timescale 1ns/1ns

module scope_cfg_decode (
  input  logic [scope_cfg_pkg::ADDR_W-1:0] sys_addr_i,
  output scope_cfg_pkg::reg_sel_t          sel_o
);

  import scope_cfg_pkg::*;

  always_comb begin
    case (sys_addr_i)
      ADR_CTRL:     sel_o = SEL_CTRL;
      ADR_TRG:      sel_o = SEL_TRG;
      ADR_TRESH0:   sel_o = SEL_TRESH0;
      ADR_TRESH1:   sel_o = SEL_TRESH1;
      ADR_DLY0:     sel_o = SEL_DLY0;
      ADR_DEC0:     sel_o = SEL_DEC0;
      ADR_WP_CUR0:  sel_o = SEL_WP_CUR0;
      ADR_WP_TRIG0: sel_o = SEL_WP_TRIG0;
      ADR_HYST0:    sel_o = SEL_HYST0;
      ADR_HYST1:    sel_o = SEL_HYST1;
      ADR_TRG_CLR:  sel_o = SEL_TRG_CLR;  // Trigger protect clear
      ADR_DLY1:     sel_o = SEL_DLY1;
      ADR_DEC1:     sel_o = SEL_DEC1;
      ADR_WP_CUR1:  sel_o = SEL_WP_CUR1;
      ADR_WP_TRIG1: sel_o = SEL_WP_TRIG1;
      default:      sel_o = SEL_NONE;     // Unmapped
    endcase
  end

endmodule

// File: design/scope_cfg_pkg.sv
// ====================
// Scope register block package: widths, types,
// address map, register selector, reset defaults
// ====================
package scope_cfg_pkg;

  localparam int N_CH   = 2;
  localparam int ADDR_W = 20;
  localparam int DW     = 14;
  localparam int RSZ    = 14;  // Buffer size 2^RSZ
  localparam int DLY_W  = 32;
  localparam int DEC_W  = 17;
  localparam int TRG_W  = 4;

  typedef logic [31:0]      word_t;
  typedef logic [DW-1:0]    sample_t;
  typedef logic [DLY_W-1:0] dly_t;
  typedef logic [DEC_W-1:0] dec_t;
  typedef logic [RSZ-1:0]   wp_t;
  typedef logic [TRG_W-1:0] trg_src_t;

  localparam logic [ADDR_W-1:0] ADR_CTRL     = 'h000;
  localparam logic [ADDR_W-1:0] ADR_TRG      = 'h004;
  localparam logic [ADDR_W-1:0] ADR_TRESH0   = 'h008;
  localparam logic [ADDR_W-1:0] ADR_TRESH1   = 'h00C;
  localparam logic [ADDR_W-1:0] ADR_DLY0     = 'h010;
  localparam logic [ADDR_W-1:0] ADR_DEC0     = 'h014;
  localparam logic [ADDR_W-1:0] ADR_WP_CUR0  = 'h018;
  localparam logic [ADDR_W-1:0] ADR_WP_TRIG0 = 'h01C;
  localparam logic [ADDR_W-1:0] ADR_HYST0    = 'h020;
  localparam logic [ADDR_W-1:0] ADR_HYST1    = 'h024;
  localparam logic [ADDR_W-1:0] ADR_TRG_CLR  = 'h094;
  localparam logic [ADDR_W-1:0] ADR_DLY1     = 'h110;
  localparam logic [ADDR_W-1:0] ADR_DEC1     = 'h114;
  localparam logic [ADDR_W-1:0] ADR_WP_CUR1  = 'h118;
  localparam logic [ADDR_W-1:0] ADR_WP_TRIG1 = 'h11C;

  typedef enum logic [3:0] {
    SEL_NONE, SEL_CTRL, SEL_TRG, SEL_TRESH0, SEL_TRESH1, SEL_DLY0, SEL_DEC0,
    SEL_WP_CUR0, SEL_WP_TRIG0, SEL_HYST0, SEL_HYST1, SEL_TRG_CLR,
    SEL_DLY1, SEL_DEC1, SEL_WP_CUR1, SEL_WP_TRIG1
  } reg_sel_t;

  localparam sample_t TRESH_RST0 = sample_t'(5000);
  localparam sample_t TRESH_RST1 = sample_t'(-5000);  // Two's complement in DW bits
  localparam sample_t HYST_RST   = sample_t'(20);
  localparam dec_t    DEC_RST    = dec_t'(1);
  localparam dly_t    DLY_RST    = '0;

  localparam int CTL_ARM   = 0;
  localparam int CTL_RST   = 1;
  localparam int CTL_KEEP  = 3;  // Stay armed after trigger
  localparam int CTL_INDEP = 5;

endpackage
